//--- source/ines_loader_pkg.sv
// ################################################
// iNES loader shared types
// Header summary, mapper flag word, memory write
// and load FSM state encodings
// ################################################

package ines_loader_pkg;

	// iNES header format
	localparam int HEADER_BYTES = 16;

	localparam logic [7:0] MAGIC_0 = 8'h4E; // 'N'
	localparam logic [7:0] MAGIC_1 = 8'h45; // 'E'
	localparam logic [7:0] MAGIC_2 = 8'h53; // 'S'
	localparam logic [7:0] MAGIC_3 = 8'h1A; // EOF marker

	// Width of the flat ROM memory address
	localparam int MEM_ADDR_BITS = 22;

	typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

	// Summary of the 16 header bytes
	typedef struct packed {
		logic       magic_ok;
		logic       trainer;
		logic       is_nes20;
		logic [7:0] prg_pages;   // 16 KB units in a real cart
		logic [7:0] chr_pages;   // 8 KB units, 0 means CHR RAM
		logic [7:0] mapper;      // Already cleaned of dirty bytes
		logic [7:0] ext_mapper;  // Byte 8 on NES 2.0, else 0
		logic       mirroring;
		logic       four_screen;
		logic       has_saves;
	} ines_header_t;

	// Word handed to the mapper logic of the core
	typedef struct packed {
		logic [5:0] reserved;
		logic       has_saves;
		logic [7:0] ext_mapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	// One byte write into ROM memory
	typedef struct packed {
		mem_addr_t  addr;
		logic [7:0] data;
		logic       write;
	} mem_write_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} load_state_t;

endpackage

//--- source/ines_header_decode.sv
// ################################################
// iNES header decode stage
// Collects the 16 header bytes and decodes them
// ################################################

`timescale 1ns/1ps

module ines_header_decode (
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         data_strobe,
	input  logic [7:0]                   data_in,
	input  ines_loader_pkg::load_state_t state,
	output ines_loader_pkg::ines_header_t header,
	output logic                         header_full
);

	logic [3:0] byte_cnt;
	logic [7:0] hdr_byte [ines_loader_pkg::HEADER_BYTES];

	logic capture;
	logic is_nes20;
	logic is_dirty;
	logic tail_nonzero;

	// Header bytes are only taken while the FSM waits for them
	assign capture = data_strobe && (state == ines_loader_pkg::LOAD_HEADER);

	assign header_full = capture &&
		(byte_cnt == 4'(ines_loader_pkg::HEADER_BYTES - 1));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			byte_cnt <= '0;
		end else if (capture) begin
			byte_cnt <= byte_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			hdr_byte[byte_cnt] <= data_in;
		end
	end

	// NES 2.0 marks itself with binary 10 in byte 7 bits 3:2
	assign is_nes20 = (hdr_byte[7][3:2] == 2'b10);

	// Old dumpers left junk in bytes 10..15
	always_comb begin
		tail_nonzero = 1'b0;
		for (int i = 10; i < ines_loader_pkg::HEADER_BYTES; i++) begin
			tail_nonzero = tail_nonzero | (hdr_byte[i] != 8'h00);
		end
	end

	assign is_dirty = !is_nes20 && ((hdr_byte[9][7:1] != 7'd0) || tail_nonzero);

	always_comb begin
		header.magic_ok    = (hdr_byte[0] == ines_loader_pkg::MAGIC_0) &&
		                     (hdr_byte[1] == ines_loader_pkg::MAGIC_1) &&
		                     (hdr_byte[2] == ines_loader_pkg::MAGIC_2) &&
		                     (hdr_byte[3] == ines_loader_pkg::MAGIC_3);
		header.trainer     = hdr_byte[6][2];
		header.is_nes20    = is_nes20;
		header.prg_pages   = hdr_byte[4];
		header.chr_pages   = hdr_byte[5];
		// Upper nibble from byte 7 cannot be trusted on a dirty header
		header.mapper      = {is_dirty ? 4'h0 : hdr_byte[7][7:4], hdr_byte[6][7:4]};
		header.ext_mapper  = is_nes20 ? hdr_byte[8] : 8'h00;
		header.mirroring   = hdr_byte[6][0]; // 1 = vertical
		header.four_screen = hdr_byte[6][3];
		header.has_saves   = hdr_byte[6][1]; // Battery backed RAM
	end

endmodule

//--- source/rom_image_writer.sv
// ################################################
// ROM image writer
// Load FSM that checks the header and streams PRG
// and CHR bytes into flat memory
// ################################################

`timescale 1ns/1ps

module rom_image_writer #(
	parameter int ADDR_WIDTH     = 22,
	parameter int PRG_PAGE_SHIFT = 14,
	parameter int CHR_PAGE_SHIFT = 13
) (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          data_strobe,
	input  logic [7:0]                    data_in,
	input  logic                          header_full,
	input  ines_loader_pkg::ines_header_t header,
	output ines_loader_pkg::load_state_t  state,
	output ines_loader_pkg::mem_write_t   mem,
	output logic                          busy,
	output logic                          done,
	output logic                          error
);

	// CHR image sits in the upper half of the address space
	localparam logic [ADDR_WIDTH-1:0] CHR_BASE = {1'b1, {(ADDR_WIDTH-1){1'b0}}};

	logic [ADDR_WIDTH-1:0] bytes_left;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [ADDR_WIDTH-1:0] prg_len;
	logic [ADDR_WIDTH-1:0] chr_len;

	logic loading;
	logic header_good;
	logic seg_end;

	assign prg_len = ADDR_WIDTH'(header.prg_pages) << PRG_PAGE_SHIFT;
	assign chr_len = ADDR_WIDTH'(header.chr_pages) << CHR_PAGE_SHIFT;

	assign header_good = header.magic_ok && !header.trainer; // Trainers not supported

	assign loading = (state == ines_loader_pkg::LOAD_PRG) ||
	                 (state == ines_loader_pkg::LOAD_CHR);

	// Segment ends on its last byte, or at once when it is empty
	assign seg_end = (bytes_left == '0) ||
	                 (data_strobe && (bytes_left == ADDR_WIDTH'(1)));

	// Write goes out in the same cycle as the strobe
	always_comb begin
		mem.addr  = ines_loader_pkg::mem_addr_t'(addr_q);
		mem.data  = data_in;
		mem.write = loading && data_strobe && (bytes_left != '0);
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= ines_loader_pkg::LOAD_HEADER;
			bytes_left <= '0;
			addr_q     <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				ines_loader_pkg::LOAD_HEADER: begin
					if (header_full) begin
						busy <= 1'b1;
						if (header_good) begin
							state      <= ines_loader_pkg::LOAD_PRG;
							addr_q     <= '0;
							bytes_left <= prg_len;
						end else begin
							state <= ines_loader_pkg::LOAD_ERROR;
						end
					end
				end

				ines_loader_pkg::LOAD_PRG: begin
					if (seg_end) begin
						state      <= ines_loader_pkg::LOAD_CHR;
						addr_q     <= CHR_BASE;
						bytes_left <= chr_len;
					end else if (data_strobe) begin
						bytes_left <= bytes_left - ADDR_WIDTH'(1);
						addr_q     <= addr_q + ADDR_WIDTH'(1);
					end
				end

				ines_loader_pkg::LOAD_CHR: begin
					if (seg_end) begin
						state <= ines_loader_pkg::LOAD_DONE;
						done  <= 1'b1;
						busy  <= 1'b0;
					end else if (data_strobe) begin
						bytes_left <= bytes_left - ADDR_WIDTH'(1);
						addr_q     <= addr_q + ADDR_WIDTH'(1);
					end
				end

				ines_loader_pkg::LOAD_ERROR: begin
					// Sticks here until the next reset
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end

				ines_loader_pkg::LOAD_DONE: begin
					busy <= 1'b0;
				end

				default: begin
					state <= ines_loader_pkg::LOAD_ERROR;
				end
			endcase
		end
	end

endmodule

//--- source/mapper_flags_result.sv
// ################################################
// Mapper flags result stage
// Encodes size codes and latches the flag word
// ################################################

`timescale 1ns/1ps

module mapper_flags_result (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           done,
	input  logic                           error,
	input  logic                           invert_mirroring,
	input  ines_loader_pkg::ines_header_t  header,
	output ines_loader_pkg::mapper_flags_t mapper_flags,
	output logic                           flags_valid
);

	ines_loader_pkg::mapper_flags_t flags_next;

	// Rounds the page count up to a power of two, as a log2 code
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		if (pages <= 8'd1)       code = 3'd0;
		else if (pages <= 8'd2)  code = 3'd1;
		else if (pages <= 8'd4)  code = 3'd2;
		else if (pages <= 8'd8)  code = 3'd3;
		else if (pages <= 8'd16) code = 3'd4;
		else if (pages <= 8'd32) code = 3'd5;
		else if (pages <= 8'd64) code = 3'd6;
		else                     code = 3'd7;
		return code;
	endfunction

	always_comb begin
		flags_next.reserved    = 6'd0;
		flags_next.has_saves   = header.has_saves;
		flags_next.ext_mapper  = header.ext_mapper;
		flags_next.four_screen = header.four_screen;
		flags_next.chr_ram     = (header.chr_pages == 8'd0); // No CHR ROM on board
		flags_next.mirroring   = header.mirroring ^ invert_mirroring;
		flags_next.chr_size    = size_code(header.chr_pages);
		flags_next.prg_size    = size_code(header.prg_pages);
		flags_next.mapper      = header.mapper;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			flags_valid <= 1'b0;
		end else if (done && !error && !flags_valid) begin
			flags_valid <= 1'b1; // One cycle behind done
		end
	end

	always_ff @(posedge clk) begin
		if (done && !error && !flags_valid) begin
			mapper_flags <= flags_next;
		end
	end

endmodule

//--- source/ines_loader_top.sv
// ################################################
// iNES cartridge loader
// Header decode, image writer and flag result
// ################################################

`timescale 1ns/1ps

module ines_loader_top #(
	parameter int ADDR_WIDTH     = 22,
	parameter int PRG_PAGE_SHIFT = 14,
	parameter int CHR_PAGE_SHIFT = 13
) (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           data_strobe,
	input  logic [7:0]                     data_in,
	input  logic                           invert_mirroring,
	output ines_loader_pkg::mem_write_t    mem,
	output logic                           busy,
	output logic                           done,
	output logic                           error,
	output ines_loader_pkg::mapper_flags_t mapper_flags,
	output logic                           flags_valid
);

	ines_loader_pkg::load_state_t  state;
	ines_loader_pkg::ines_header_t header;
	logic                          header_full;

	ines_header_decode u_decode (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.data_strobe (data_strobe),
		.data_in     (data_in),
		.state       (state),
		.header      (header),
		.header_full (header_full)
	);

	rom_image_writer #(
		.ADDR_WIDTH     (ADDR_WIDTH),
		.PRG_PAGE_SHIFT (PRG_PAGE_SHIFT),
		.CHR_PAGE_SHIFT (CHR_PAGE_SHIFT)
	) u_writer (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.data_strobe (data_strobe),
		.data_in     (data_in),
		.header_full (header_full),
		.header      (header),
		.state       (state),
		.mem         (mem),
		.busy        (busy),
		.done        (done),
		.error       (error)
	);

	mapper_flags_result u_result (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.done             (done),
		.error            (error),
		.invert_mirroring (invert_mirroring),
		.header           (header),
		.mapper_flags     (mapper_flags),
		.flags_valid      (flags_valid)
	);

endmodule

//--- include/ines_ref_model.svh
// ################################################
// Reference model for the iNES loader testbench
// Expected flag word, write addresses and payload
// ################################################

// CHR image base, top address bit set for a 22-bit space
localparam logic [21:0] REF_CHR_BASE = 22'h200000;

// Smallest power of two that holds the page count, as a log2 code
function automatic logic [2:0] ref_size_code(input logic [7:0] pages);
	int code;
	code = 0;
	while ((code < 7) && ((1 << code) < int'(pages))) begin
		code++;
	end
	return 3'(code);
endfunction

// Expected mapper flag word from the raw header bytes
function automatic logic [31:0] ref_mapper_flags(input logic [127:0] hdr, input logic invert);
	logic [7:0] f6;
	logic [7:0] f7;
	logic [7:0] f9;
	logic [7:0] ext;
	logic [7:0] mapper;
	logic       nes20;
	logic       tail;
	logic       dirty;
	f6 = hdr[55:48];
	f7 = hdr[63:56];
	f9 = hdr[79:72];
	nes20 = (f7[3:2] == 2'b10);
	tail = 1'b0;
	for (int k = 10; k < 16; k++) begin
		tail = tail | (hdr[8*k +: 8] != 8'h00);
	end
	dirty = !nes20 && ((f9[7:1] != 7'd0) || tail); // Junk in the tail bytes
	ext = nes20 ? hdr[71:64] : 8'h00;
	mapper = {(dirty ? 4'h0 : f7[7:4]), f6[7:4]};
	return {6'd0, f6[1], ext, f6[3], (hdr[47:40] == 8'h00), f6[0] ^ invert,
		ref_size_code(hdr[47:40]), ref_size_code(hdr[39:32]), mapper};
endfunction

// PRG from 0, CHR from the base once PRG is complete
function automatic logic [21:0] ref_write_addr(input int index, input int prg_bytes);
	if (index < prg_bytes) begin
		return 22'(index);
	end
	return REF_CHR_BASE + 22'(index - prg_bytes);
endfunction

function automatic logic [7:0] ref_payload(input int index);
	return 8'(index * 7 + 3);
endfunction

//--- testbench/tb_ines_loader.sv
// ################################################
// Testbench for the iNES cartridge loader
// Streams headers and images, checks writes/flags
// ################################################

`timescale 1ns/1ps

module tb_ines_loader;

	localparam int ADDR_WIDTH     = 22;
	localparam int PRG_PAGE_SHIFT = 4;  // 16-byte PRG pages
	localparam int CHR_PAGE_SHIFT = 3;  // 8-byte CHR pages
	localparam int HEADER_BYTES   = 16;
	localparam int TIMEOUT_CYCLES = 4000; // Longest load is a few hundred cycles

	logic       clk = 1'b0;
	logic       reset_nes;
	logic       data_strobe;
	logic [7:0] data_in;
	logic       invert_mirroring;

	ines_loader_pkg::mem_write_t    mem;
	logic                           busy;
	logic                           done;
	logic                           error;
	ines_loader_pkg::mapper_flags_t mapper_flags;
	logic                           flags_valid;

	integer seed;
	int     cycle_count = 0;
	int     cmp_errors = 0;
	int     chk_errors = 0;
	int     test_num = 0;
	int     tests_failed = 0;
	int     write_idx = 0;
	int     exp_total = 0;
	int     exp_prg_bytes = 0;
	logic   done_d = 1'b0;
	logic   done_dd = 1'b0;

	`include "ines_ref_model.svh"

	ines_loader_top #(
		.ADDR_WIDTH     (ADDR_WIDTH),
		.PRG_PAGE_SHIFT (PRG_PAGE_SHIFT),
		.CHR_PAGE_SHIFT (CHR_PAGE_SHIFT)
	) uut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.data_strobe      (data_strobe),
		.data_in          (data_in),
		.invert_mirroring (invert_mirroring),
		.mem              (mem),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.flags_valid      (flags_valid)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Outputs are sampled mid-cycle, away from the clock edge and input changes
	always @(negedge clk) begin
		if (reset_nes) begin
			write_idx = 0;
			done_d = 1'b0;
			done_dd = 1'b0;
		end else begin
			if (mem.write) begin
				if (busy !== 1'b1) begin
					$display("FAIL busy: expected 1, got %h", busy);
					cmp_errors++;
				end
				if (write_idx >= exp_total) begin
					$display("unexpected memory write to address %h", mem.addr);
					cmp_errors++;
				end else begin
					if (mem.addr !== ref_write_addr(write_idx, exp_prg_bytes)) begin
						$display("FAIL mem.addr: expected %h, got %h",
							ref_write_addr(write_idx, exp_prg_bytes), mem.addr);
						cmp_errors++;
					end
					if (mem.data !== ref_payload(write_idx)) begin
						$display("FAIL mem.data: expected %h, got %h",
							ref_payload(write_idx), mem.data);
						cmp_errors++;
					end
				end
				write_idx++;
			end
			if (done && !done_d && flags_valid) begin
				$display("flags_valid was already high when done rose");
				cmp_errors++;
			end
			if (done_d && !done_dd && (flags_valid !== !error)) begin
				$display("flags_valid did not follow done one cycle later");
				cmp_errors++;
			end
			done_dd = done_d;
			done_d = done;
		end
	end

	function automatic logic [127:0] build_header(input logic [7:0] prg, input logic [7:0] chr,
		input logic [7:0] f6, input logic [7:0] f7, input logic [7:0] f8, input logic [7:0] f12);
		logic [127:0] hdr;
		hdr = '0;
		hdr[31:0] = 32'h1A53454E; // "NES" and EOF, byte 0 lowest
		hdr[39:32] = prg;
		hdr[47:40] = chr;
		hdr[55:48] = f6;
		hdr[63:56] = f7;
		hdr[71:64] = f8;
		hdr[103:96] = f12;
		return hdr;
	endfunction

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, got %h", name, expected, actual);
			chk_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, got %h", name, expected, actual);
			chk_errors++;
		end
	endtask

	task automatic apply_reset();
		reset_nes = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset_nes = 1'b0;
	endtask

	// One strobe cycle, then a random idle gap
	task automatic send_byte(input logic [7:0] value);
		logic [1:0] gap;
		gap = 2'($random(seed));
		data_in = value;
		data_strobe = 1'b1;
		@(posedge clk);
		#1;
		data_strobe = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_load(input string name, input logic [127:0] hdr, input logic invert,
		input logic expect_error);
		int prg_bytes;
		int chr_bytes;
		int n_payload;
		int errs_before;
		test_num++;
		errs_before = chk_errors + cmp_errors;
		prg_bytes = int'(hdr[39:32]) << PRG_PAGE_SHIFT;
		chr_bytes = int'(hdr[47:40]) << CHR_PAGE_SHIFT;
		exp_prg_bytes = prg_bytes;
		exp_total = expect_error ? 0 : prg_bytes + chr_bytes;
		n_payload = expect_error ? 8 : prg_bytes + chr_bytes; // Error loads get a short tail
		invert_mirroring = invert;
		apply_reset();
		@(negedge clk);
		check_bit("busy", 1'b0, busy);
		check_bit("done", 1'b0, done);
		check_bit("error", 1'b0, error);
		check_bit("flags_valid", 1'b0, flags_valid);
		@(posedge clk);
		#1;
		for (int k = 0; k < HEADER_BYTES; k++) begin
			send_byte(hdr[8*k +: 8]);
		end
		for (int i = 0; i < n_payload; i++) begin
			send_byte(ref_payload(i));
		end
		@(negedge clk);
		while (!done) @(negedge clk);
		@(posedge clk);
		#1;
		repeat (3) send_byte(8'hA5); // Strays past the end of the image
		@(negedge clk);
		check_bit("done", 1'b1, done);
		check_bit("error", expect_error, error);
		check_bit("busy", 1'b0, busy);
		check_bit("flags_valid", !expect_error, flags_valid);
		check_word("write count", 32'(exp_total), 32'(write_idx));
		if (!expect_error) begin
			check_word("mapper_flags", ref_mapper_flags(hdr, invert), mapper_flags);
		end
		@(posedge clk);
		#1;
		if (chk_errors + cmp_errors == errs_before) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: failed", test_num, name);
			tests_failed++;
		end
	endtask

	initial begin
		logic [127:0] hdr;
		seed = 32'h8fd3;
		reset_nes = 1'b1;
		data_strobe = 1'b0;
		data_in = 8'h00;
		invert_mirroring = 1'b0;
		@(posedge clk);
		#1;

		run_load("ines 1.0 image", build_header(8'd2, 8'd1, 8'h13, 8'h20, 8'h00, 8'h00),
			1'b0, 1'b0);
		run_load("zero chr pages", build_header(8'd1, 8'd0, 8'h08, 8'h00, 8'h00, 8'h00),
			1'b0, 1'b0);
		run_load("dirty header", build_header(8'd1, 8'd1, 8'h40, 8'h30, 8'h00, 8'h44),
			1'b0, 1'b0);
		run_load("nes 2.0 header", build_header(8'd1, 8'd1, 8'h40, 8'h38, 8'h05, 8'h44),
			1'b0, 1'b0);

		// Size sweep with mirroring inverted
		run_load("sweep 1/2", build_header(8'd1, 8'd2, 8'h01, 8'h00, 8'h00, 8'h00),
			1'b1, 1'b0);
		run_load("sweep 3/5", build_header(8'd3, 8'd5, 8'h00, 8'h00, 8'h00, 8'h00),
			1'b1, 1'b0);
		run_load("sweep 4/9", build_header(8'd4, 8'd9, 8'h03, 8'h00, 8'h00, 8'h00),
			1'b1, 1'b0);
		run_load("sweep 2/17", build_header(8'd2, 8'd17, 8'h00, 8'h10, 8'h00, 8'h00),
			1'b1, 1'b0);

		hdr = build_header(8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00);
		hdr[31:24] = 8'h1B; // Broken EOF marker
		run_load("bad signature", hdr, 1'b0, 1'b1);
		run_load("trainer set", build_header(8'd1, 8'd1, 8'h04, 8'h00, 8'h00, 8'h00),
			1'b0, 1'b1);

		$display("%0d tests, %0d failed, %0d check errors", test_num, tests_failed,
			chk_errors + cmp_errors);
		if (chk_errors + cmp_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
source/ines_loader_pkg.sv
source/ines_header_decode.sv
source/rom_image_writer.sv
source/mapper_flags_result.sv
source/ines_loader_top.sv
testbench/tb_ines_loader.sv

//--- Makefile
TOP = tb_ines_loader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
